// File: ice_bus.f
hw/ice_bus_pkg.sv
hw/ice_frame_rx.sv
hw/ice_resp_arbiter.sv
hw/basics_regs.sv
hw/gpio_int.sv
hw/ice_bus.sv
testbench/ice_bus_properties.sv
testbench/ice_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -Wno-fatal -j 0
TOP := ice_bus_tb
FILELIST := ice_bus.f
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "FAIL: no result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/ice_bus_tb.sv
module ice_bus_tb;
	import ice_bus_pkg::*;

	localparam int NT = 12;
	localparam int BUDGET = 150;
	localparam int LIMIT = NT * BUDGET;

	logic clk;
	logic arst_n;
	logic [7:0] rx_data;
	logic rx_valid;
	logic rx_credit;
	logic [7:0] tx_data;
	logic tx_valid;
	logic tx_last;
	logic tx_credit = 1'b0;
	logic [7:0] gpio_in;
	logic [7:0] gpio_out;
	logic [7:0] gpio_oe;

	// Stimulus table with one row per test
	logic [7:0] fr_b [NT][16];
	logic [7:0] ex_b [NT][16];
	logic [15:0] ex_last [NT];
	int fr_n [NT];
	int ex_n [NT];
	int dly_v [NT];
	logic [7:0] gin_v [NT];
	logic [7:0] dir_v [NT];
	logic [7:0] lvl_v [NT];
	logic [7:0] fq [$];
	logic [7:0] eq [$];
	logic [15:0] last_m = '0;
	int nt = 0;
	logic [7:0] dir_m = '0;
	logic [7:0] lvl_m = '0;

	// Host side state
	logic [7:0] got [$];
	logic lastq [$];
	int due [$];
	int rx_cred = 4;
	int tx_cred = 4;
	int tx_dly = 0;
	int cyc = 0;
	int errors = 0;
	logic [31:0] seed = 32'd21;

	ice_bus u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [7:0] rnd();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[23:16];
	endfunction

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, act, exp);
			errors++;
		end
	endtask

	// Copy staged frame and reply into the next row
	task automatic commit(input logic [7:0] gin, input int dly);
		fr_n[nt] = fq.size();
		ex_n[nt] = eq.size();
		for (int k = 0; k < fq.size(); k++) fr_b[nt][k] = fq[k];
		for (int k = 0; k < eq.size(); k++) ex_b[nt][k] = eq[k];
		// Final byte of the row always closes a reply
		ex_last[nt] = last_m;
		if (eq.size() > 0) ex_last[nt][eq.size() - 1] = 1'b1;
		last_m = '0;
		gin_v[nt] = gin;
		dir_v[nt] = dir_m;
		lvl_v[nt] = lvl_m;
		dly_v[nt] = dly;
		nt++;
		fq.delete();
		eq.delete();
	endtask

	// Expected replies built from the protocol rules and a local event count
	task automatic build_table();
		logic [7:0] g;
		logic [7:0] evc;
		g = '0;
		evc = '0;
		fq = {8'h01, 8'h01, OP_QUERY};
		eq = {ADDR_BASICS, VERSION_ID};
		commit(g, 0);
		fq = {8'h07, 8'h00};
		eq = {ADDR_BASICS, NAK_CHAR};
		commit(g, 0);
		fq = {8'h01, 8'h00};
		eq = {ADDR_BASICS, NAK_CHAR};
		commit(g, 0);
		// Pin 0 stays an input, pin 7 an output
		dir_m = (rnd() & 8'hFE) | 8'h80;
		fq = {8'h01, 8'h02, OP_WR_DIR, dir_m};
		eq = {ADDR_BASICS, ACK_CHAR};
		commit(g, 1);
		lvl_m = rnd();
		fq = {8'h01, 8'h02, OP_WR_LVL, lvl_m};
		eq = {ADDR_BASICS, ACK_CHAR};
		commit(g, 2);
		fq = {8'h02, 8'h00};
		eq = {ADDR_GPIO, evc, g & ~dir_m};
		commit(g, 0);
		// Unsolicited events on input pins
		for (int e = 0; e < 2; e++) begin
			g = g ^ ((rnd() & ~dir_m) | 8'h01);
			evc++;
			eq = {ADDR_GPIO, evc, g & ~dir_m};
			commit(g, e * 3);
		end
		// Output pins only so no event follows
		g = g ^ ((rnd() | 8'h80) & dir_m);
		commit(g, 0);
		fq = {8'h01, 8'h01, OP_RD_REG};
		eq = {ADDR_BASICS, dir_m, lvl_m, g};
		commit(g, 0);
		fq = {8'h02, 8'h00};
		eq = {ADDR_GPIO, evc, g & ~dir_m};
		commit(g, 1);
		// Three frames back to back with slow credit return
		lvl_m = rnd();
		fq = {8'h01, 8'h01, OP_QUERY, 8'h01, 8'h02, OP_WR_LVL, lvl_m, 8'h01, 8'h01, OP_RD_REG};
		eq = {ADDR_BASICS, VERSION_ID, ADDR_BASICS, ACK_CHAR, ADDR_BASICS, dir_m, lvl_m, g};
		// First two replies end at bytes 1 and 3
		last_m = 16'h000A;
		commit(g, 6);
	endtask

	// Waits for a host credit before each byte
	task automatic send_byte(input logic [7:0] b);
		@(negedge clk);
		while (rx_cred == 0) begin
			rx_valid = 1'b0;
			@(negedge clk);
		end
		rx_valid = 1'b1;
		rx_data = b;
		rx_cred--;
	endtask

	// Host receiver, credit bookkeeping and run limit
	always @(negedge clk) begin
		if (arst_n) begin
			cyc++;
			if (rx_credit) rx_cred++;
			// Credit driven last cycle reached the DUT at the rising edge
			if (tx_credit) tx_cred++;
			tx_credit = 1'b0;
			if (tx_valid) begin
				if (tx_cred == 0) begin
					$display("ERROR: tx_valid at %0t while the host holds no credit", $time);
					errors++;
				end
				tx_cred--;
				got.push_back(tx_data);
				lastq.push_back(tx_last);
				due.push_back(cyc + 1 + tx_dly);
			end
			// One credit back per cycle once its delay is over
			if (due.size() > 0 && due[0] <= cyc) begin
				tx_credit = 1'b1;
				void'(due.pop_front());
			end
			if (cyc > LIMIT) begin
				$display("ERROR: timeout after %0d cycles", cyc);
				$display("sim failed");
				$finish;
			end
		end
	end

	initial begin
		int err0;
		int waited;
		arst_n = 1'b0;
		rx_valid = 1'b0;
		rx_data = '0;
		gpio_in = '0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < NT; i++) begin
			err0 = errors;
			got.delete();
			lastq.delete();
			gpio_in = gin_v[i];
			tx_dly = dly_v[i];
			for (int k = 0; k < fr_n[i]; k++) send_byte(fr_b[i][k]);
			@(negedge clk);
			rx_valid = 1'b0;
			waited = 0;
			while (got.size() < ex_n[i] && waited < BUDGET) begin
				@(negedge clk);
				waited++;
			end
			if (got.size() < ex_n[i]) begin
				$display("ERROR: test %0d reply incomplete, %0d of %0d bytes",
					i, got.size(), ex_n[i]);
				errors++;
			end
			// Quiet window catches stray bytes
			repeat (ex_n[i] == 0 ? 40 : 10) @(negedge clk);
			check("resp_len", got.size(), ex_n[i]);
			for (int k = 0; k < ex_n[i] && k < got.size(); k++) begin
				check("tx_data", got[k], ex_b[i][k]);
				check("tx_last", lastq[k], ex_last[i][k]);
			end
			check("gpio_oe", gpio_oe, dir_v[i]);
			check("gpio_out", gpio_out, lvl_v[i]);
			$display("test %0d %s", i, (errors == err0) ? "ok" : "FAIL");
		end
		$display("tests %0d, errors %0d", NT, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: testbench/ice_bus_properties.sv
module ice_bus_properties #(
	parameter int LIMIT = 4,
	parameter bit HAS_GRANT = 1'b1
) (
	input logic clk,
	input logic arst_n,
	input logic spend,
	input logic give,
	input ice_bus_pkg::sl_resp_t [ice_bus_pkg::NUM_DEV-1:0] resp,
	input logic [ice_bus_pkg::NUM_DEV-1:0] sel
);
	import ice_bus_pkg::*;

	// Credits held by the sending side, seen from the link pins only
	int credits;
	logic [NUM_DEV-1:0] req;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= LIMIT;
		end else begin
			credits <= credits - int'(spend) + int'(give);
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_DEV; i++) begin
			req[i] = resp[i].req;
		end
	end

	// A byte only goes out against a held credit
	a_spend_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
		spend |-> credits != 0)
		else $error("byte sent without a credit");

	// Never more credits back than bytes sent
	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= LIMIT)
		else $error("credit count above its limit");

	if (HAS_GRANT) begin : g_grant
		// At most one device owns the response bus and it is asking
		a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
			$onehot0(sel) && (sel & ~req) == '0)
			else $error("grant not one-hot or held by an idle device");
	end

endmodule

// Credits toward the host
bind ice_resp_arbiter ice_bus_properties #(.LIMIT(TX_CREDITS)) u_arb_props (
	.clk(clk),
	.arst_n(arst_n),
	.spend(tx_valid),
	.give(tx_credit),
	.resp(resp),
	.sel(grant)
);

// Credits the host holds for the receive FIFO
bind ice_frame_rx ice_bus_properties #(.LIMIT(RX_DEPTH), .HAS_GRANT(1'b0)) u_rx_props (
	.clk(clk),
	.arst_n(arst_n),
	.spend(rx_valid),
	.give(rx_credit),
	.resp('0),
	.sel('0)
);

// File: hw/ice_bus.sv
module ice_bus #(
	parameter int GPIO_W = 8,
	parameter int RX_DEPTH = 4,
	parameter int TX_CREDITS = 4
) (
	input logic clk,
	input logic arst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	output logic rx_credit,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic tx_last,
	input logic tx_credit,
	input logic [GPIO_W-1:0] gpio_in,
	output logic [GPIO_W-1:0] gpio_out,
	output logic [GPIO_W-1:0] gpio_oe
);
	import ice_bus_pkg::*;

	// Shared master bus and per device response lines
	ma_bus_t ma_bus;
	sl_resp_t [NUM_DEV-1:0] resp;
	logic [NUM_DEV-1:0] grant;
	logic [NUM_DEV-1:0] busy;
	logic take;

	// Settings from basics that steer the pins
	logic [GPIO_W-1:0] gpio_dir;
	logic [GPIO_W-1:0] gpio_lvl;
	logic [GPIO_W-1:0] gpio_sync;

	// Host bytes in, frames out on the master bus
	ice_frame_rx #(.RX_DEPTH(RX_DEPTH)) rx0 (
		.clk(clk),
		.arst_n(arst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_credit(rx_credit),
		.busy(busy),
		.ma_bus(ma_bus)
	);

	// Device replies back to the host
	ice_resp_arbiter #(.TX_CREDITS(TX_CREDITS)) arb0 (
		.clk(clk),
		.arst_n(arst_n),
		.resp(resp),
		.grant(grant),
		.take(take),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_last(tx_last),
		.tx_credit(tx_credit)
	);

	// Device 0, also answers immediate NAKs
	basics_regs #(.GPIO_W(GPIO_W)) bi0 (
		.clk(clk),
		.arst_n(arst_n),
		.ma_bus(ma_bus),
		.resp(resp[0]),
		.grant(grant[0]),
		.take(take),
		.busy(busy[0]),
		.gpio_dir(gpio_dir),
		.gpio_lvl(gpio_lvl),
		.gpio_sync(gpio_sync)
	);

	// Device 1
	gpio_int #(.GPIO_W(GPIO_W)) gi1 (
		.clk(clk),
		.arst_n(arst_n),
		.ma_bus(ma_bus),
		.gpio_in(gpio_in),
		.gpio_dir(gpio_dir),
		.gpio_lvl(gpio_lvl),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.gpio_sync(gpio_sync),
		.resp(resp[1]),
		.grant(grant[1]),
		.take(take),
		.busy(busy[1])
	);

endmodule

// File: hw/gpio_int.sv
module gpio_int #(
	parameter int GPIO_W = 8
) (
	input logic clk,
	input logic arst_n,
	input ice_bus_pkg::ma_bus_t ma_bus,
	input logic [GPIO_W-1:0] gpio_in,
	input logic [GPIO_W-1:0] gpio_dir,
	input logic [GPIO_W-1:0] gpio_lvl,
	output logic [GPIO_W-1:0] gpio_out,
	output logic [GPIO_W-1:0] gpio_oe,
	output logic [GPIO_W-1:0] gpio_sync,
	output ice_bus_pkg::sl_resp_t resp,
	input logic grant,
	input logic take,
	output logic busy
);
	import ice_bus_pkg::*;

	logic [GPIO_W-1:0] sync_1;
	logic [GPIO_W-1:0] sync_prev;
	logic [GPIO_W-1:0] masked;
	logic in_frame_q, frame_end, change;
	logic pend, started, sent, dirty;
	logic evt_now, snap_now, load;
	logic [1:0] idx;
	logic [7:0] ev_count, ev_count_nxt;
	logic [7:0] cnt_buf, dat_buf;
	logic [7:0] resp_data;

	assign gpio_out = gpio_lvl;
	assign gpio_oe = gpio_dir;

	// Only pins configured as inputs are reported
	assign masked = gpio_sync & ~gpio_dir;
	assign change = |((gpio_sync ^ sync_prev) & ~gpio_dir);
	assign frame_end = in_frame_q && !ma_bus.frame_valid;

	assign started = pend && idx != 2'd0;
	assign sent = grant && take && idx == 2'd2;
	// New event, or a change that arrived during a send
	assign evt_now = (change && (!pend || sent)) || (sent && dirty);
	assign snap_now = frame_end && (!pend || sent);
	// Unsent reply just gets fresh data
	assign load = evt_now || snap_now || (pend && !started && (change || frame_end));
	assign ev_count_nxt = evt_now ? ev_count + 8'd1 : ev_count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_1 <= '0;
			gpio_sync <= '0;
			sync_prev <= '0;
			in_frame_q <= 1'b0;
			pend <= 1'b0;
			dirty <= 1'b0;
			idx <= '0;
			ev_count <= '0;
		end else begin
			sync_1 <= gpio_in;
			gpio_sync <= sync_1;
			sync_prev <= gpio_sync;
			in_frame_q <= ma_bus.frame_valid && ma_bus.addr == ADDR_GPIO;
			ev_count <= ev_count_nxt;
			if (evt_now || snap_now) begin
				pend <= 1'b1;
			end else if (sent) begin
				pend <= 1'b0;
			end
			if (sent) begin
				dirty <= 1'b0;
			end else if (change && started) begin
				dirty <= 1'b1;
			end
			if (sent) begin
				idx <= '0;
			end else if (grant && take) begin
				idx <= idx + 1'b1;
			end
		end
	end

	// Time tag and pin image
	always_ff @(posedge clk) begin
		if (load) begin
			cnt_buf <= ev_count_nxt;
			dat_buf <= 8'(masked);
		end
	end

	always_comb begin
		case (idx)
			2'd0: resp_data = ADDR_GPIO;
			2'd1: resp_data = cnt_buf;
			default: resp_data = dat_buf;
		endcase
	end

	assign busy = pend || frame_end;
	assign resp = '{req: busy, data: resp_data, last: idx == 2'd2};

endmodule

// File: hw/basics_regs.sv
module basics_regs #(
	parameter int GPIO_W = 8
) (
	input logic clk,
	input logic arst_n,
	input ice_bus_pkg::ma_bus_t ma_bus,
	output ice_bus_pkg::sl_resp_t resp,
	input logic grant,
	input logic take,
	output logic busy,
	output logic [GPIO_W-1:0] gpio_dir,
	output logic [GPIO_W-1:0] gpio_lvl,
	input logic [GPIO_W-1:0] gpio_sync
);
	import ice_bus_pkg::*;

	logic in_frame_q;
	logic frame_end;
	logic load;
	logic pend;
	logic [1:0] pay_cnt;
	logic [1:0] idx;
	logic [1:0] last_idx;
	basics_op_e op_q;
	logic [7:0] arg_q;
	logic [1:0] ld_last;
	logic [7:0] ld_b1, ld_b2, ld_b3;
	logic [7:0] b1_q, b2_q, b3_q;
	logic [7:0] resp_data;
	logic wr_dir, wr_lvl;

	// Frame to us just closed
	assign frame_end = in_frame_q && !ma_bus.frame_valid;
	assign load = frame_end || ma_bus.nak;

	// Command decode, NAK unless something matches
	always_comb begin
		ld_last = 2'd1;
		ld_b1 = NAK_CHAR;
		ld_b2 = '0;
		ld_b3 = '0;
		wr_dir = 1'b0;
		wr_lvl = 1'b0;
		if (frame_end && pay_cnt != 2'd0) begin
			case (op_q)
				OP_QUERY: ld_b1 = VERSION_ID;
				OP_WR_DIR: begin
					wr_dir = pay_cnt == 2'd2;
					ld_b1 = wr_dir ? ACK_CHAR : NAK_CHAR;
				end
				OP_WR_LVL: begin
					wr_lvl = pay_cnt == 2'd2;
					ld_b1 = wr_lvl ? ACK_CHAR : NAK_CHAR;
				end
				OP_RD_REG: begin
					ld_last = 2'd3;
					ld_b1 = 8'(gpio_dir);
					ld_b2 = 8'(gpio_lvl);
					ld_b3 = 8'(gpio_sync);
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_frame_q <= 1'b0;
			pay_cnt <= '0;
			pend <= 1'b0;
			idx <= '0;
			last_idx <= '0;
			gpio_dir <= '0;
			gpio_lvl <= '0;
		end else begin
			in_frame_q <= ma_bus.frame_valid && ma_bus.addr == ADDR_BASICS;
			// Counts payload bytes, saturates once the argument is in
			if (!in_frame_q) begin
				pay_cnt <= '0;
			end else if (ma_bus.data_valid && pay_cnt != 2'd2) begin
				pay_cnt <= pay_cnt + 1'b1;
			end
			if (wr_dir) begin
				gpio_dir <= GPIO_W'(arg_q);
			end
			if (wr_lvl) begin
				gpio_lvl <= GPIO_W'(arg_q);
			end
			if (load) begin
				pend <= 1'b1;
				idx <= '0;
				last_idx <= ld_last;
			end else if (grant && take) begin
				pend <= !resp.last;
				idx <= resp.last ? 2'd0 : idx + 1'b1;
			end
		end
	end

	// Opcode, argument and reply bytes
	always_ff @(posedge clk) begin
		if (in_frame_q && ma_bus.data_valid && pay_cnt == 2'd0) begin
			op_q <= basics_op_e'(ma_bus.data);
		end
		if (in_frame_q && ma_bus.data_valid && pay_cnt == 2'd1) begin
			arg_q <= ma_bus.data;
		end
		if (load) begin
			b1_q <= ld_b1;
			b2_q <= ld_b2;
			b3_q <= ld_b3;
		end
	end

	always_comb begin
		case (idx)
			2'd0: resp_data = ADDR_BASICS;
			2'd1: resp_data = b1_q;
			2'd2: resp_data = b2_q;
			default: resp_data = b3_q;
		endcase
	end

	// Busy as soon as the frame ends so the parser holds the next header
	assign busy = pend || frame_end;
	assign resp = '{req: busy, data: resp_data, last: idx == last_idx};

endmodule

// File: hw/ice_resp_arbiter.sv
module ice_resp_arbiter #(
	parameter int TX_CREDITS = 4
) (
	input logic clk,
	input logic arst_n,
	input ice_bus_pkg::sl_resp_t [ice_bus_pkg::NUM_DEV-1:0] resp,
	output logic [ice_bus_pkg::NUM_DEV-1:0] grant,
	output logic take,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic tx_last,
	input logic tx_credit
);
	import ice_bus_pkg::*;

	localparam int CW = $clog2(TX_CREDITS + 1);

	logic [CW-1:0] credit_cnt;
	logic [NUM_DEV-1:0] pick;
	sl_resp_t sel;

	// Lowest index wins, so scan from the top down
	always_comb begin
		pick = '0;
		for (int i = NUM_DEV - 1; i >= 0; i--) begin
			if (resp[i].req) begin
				pick = NUM_DEV'(1) << i;
			end
		end
	end

	// Offer from the granted device, zero when idle
	always_comb begin
		sel = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (grant[i]) begin
				sel = resp[i];
			end
		end
	end

	// No credit means the byte and the grant both wait
	assign tx_valid = sel.req && credit_cnt != '0;
	assign tx_data = sel.data;
	assign tx_last = sel.last;
	assign take = tx_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			grant <= '0;
			credit_cnt <= CW'(TX_CREDITS);
		end else begin
			// Grant lasts for the whole response
			if (grant == '0) begin
				grant <= pick;
			end else if (take && sel.last) begin
				grant <= '0;
			end
			// One credit per byte, host returns them one at a time
			case ({take, tx_credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: begin
					if (credit_cnt != CW'(TX_CREDITS)) begin
						credit_cnt <= credit_cnt + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hw/ice_frame_rx.sv
module ice_frame_rx #(
	parameter int RX_DEPTH = 4
) (
	input logic clk,
	input logic arst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	output logic rx_credit,
	input logic [ice_bus_pkg::NUM_DEV-1:0] busy,
	output ice_bus_pkg::ma_bus_t ma_bus
);
	import ice_bus_pkg::*;

	localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
	localparam int CNT_W = $clog2(RX_DEPTH + 1);

	typedef enum logic [2:0] {ST_HDR, ST_LEN, ST_PAY, ST_NAK, ST_END} state_e;

	logic [7:0] fifo_mem [RX_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fifo_cnt;
	logic [7:0] head;
	logic pop;
	logic hdr_stall;
	logic known;
	logic [3:0] remain;
	state_e state;

	assign head = fifo_mem[rd_ptr];

	// Hold a header back while its device still owes a reply
	always_comb begin
		case (head)
			ADDR_BASICS: hdr_stall = busy[0];
			ADDR_GPIO: hdr_stall = busy[1];
			default: hdr_stall = 1'b0;
		endcase
	end

	// One byte per cycle inside a frame
	assign pop = fifo_cnt != '0 &&
		(state == ST_LEN || state == ST_PAY || (state == ST_HDR && !hdr_stall));

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			fifo_mem[wr_ptr] <= rx_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			rx_credit <= 1'b0;
		end else begin
			// Host gets its slot back for every byte consumed
			rx_credit <= pop;
			if (rx_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({rx_valid, pop})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	// Beat appears the cycle after its byte is popped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_HDR;
			remain <= '0;
			known <= 1'b0;
			ma_bus <= '0;
		end else begin
			ma_bus.data_valid <= 1'b0;
			ma_bus.nak <= 1'b0;
			// Stays up across FIFO underrun mid frame
			ma_bus.frame_valid <= state == ST_LEN || state == ST_PAY;
			case (state)
				ST_HDR: begin
					if (pop) begin
						ma_bus.addr <= head;
						ma_bus.frame_valid <= 1'b1;
						known <= head == ADDR_BASICS || head == ADDR_GPIO;
						state <= ST_LEN;
					end
				end
				ST_LEN: begin
					if (pop) begin
						remain <= head[3:0];
						if (head[3:0] == 4'd0) begin
							state <= known ? ST_END : ST_NAK;
						end else begin
							state <= ST_PAY;
						end
					end
				end
				ST_PAY: begin
					if (pop) begin
						ma_bus.data <= head;
						ma_bus.data_valid <= 1'b1;
						remain <= remain - 1'b1;
						if (remain == 4'd1) begin
							state <= known ? ST_END : ST_NAK;
						end
					end
				end
				ST_NAK: begin
					// Basics answers the NAK, so wait until it is free
					if (!busy[0]) begin
						ma_bus.nak <= 1'b1;
						state <= ST_END;
					end
				end
				// Idle beat so devices see the frame end and raise busy
				ST_END: state <= ST_HDR;
				default: state <= ST_HDR;
			endcase
		end
	end

endmodule

// File: hw/ice_bus_pkg.sv
package ice_bus_pkg;

	// Master bus beat, broadcast to every device
	typedef struct packed {
		// Destination of the current frame
		logic [7:0] addr;
		// Payload byte
		logic [7:0] data;
		// Payload byte present this cycle
		logic data_valid;
		// Header through last payload byte
		logic frame_valid;
		// End of a frame nobody owns
		logic nak;
	} ma_bus_t;

	// Response offer from one device
	typedef struct packed {
		logic req;
		logic [7:0] data;
		// Final byte of the response
		logic last;
	} sl_resp_t;

	// Basics commands are printable characters
	typedef enum logic [7:0] {
		// 'V'
		OP_QUERY = 8'h56,
		// 'D'
		OP_WR_DIR = 8'h44,
		// 'L'
		OP_WR_LVL = 8'h4C,
		// 'R'
		OP_RD_REG = 8'h52
	} basics_op_e;

	// Address map
	localparam logic [7:0] ADDR_BASICS = 8'h01;
	localparam logic [7:0] ADDR_GPIO = 8'h02;

	// Device 0 is basics, device 1 is GPIO
	localparam int NUM_DEV = 2;

	// Reply characters
	localparam logic [7:0] ACK_CHAR = 8'h06;
	localparam logic [7:0] NAK_CHAR = 8'h15;
	localparam logic [7:0] VERSION_ID = 8'h31;

endpackage
